// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_ecc
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
RUN_ARGS  = +verilator+error+limit+100
LOG       = sim.log
PASS_MSG  = sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== filelist.f ====
hw/ecc_pkg.sv
hw/ecc_apb_regs.sv
hw/ecc_encode_stage.sv
hw/ecc_syndrome_stage.sv
hw/ecc_correct_stage.sv
hw/ecc_top.sv
sim/ecc_chk.sv
sim/ecc_monitor.sv
sim/tb_ecc.sv

// ==== hw/ecc_apb_regs.sv ====
`timescale 1ns/1ps

module ecc_apb_regs (
    input  logic                  clk,
    input  logic                  arst_n,
    input  ecc_pkg::apb_req_t     apb_req,
    output ecc_pkg::apb_rsp_t     apb_rsp,
    output ecc_pkg::ecc_op_t      op,
    input  ecc_pkg::ecc_result_t  result
);

    ecc_pkg::data_t   data_in;
    ecc_pkg::parity_t parity_in;
    logic             bypass;
    ecc_pkg::data_t   data_out;
    ecc_pkg::parity_t parity_out;
    logic             done;
    logic             sbit;
    logic             dbit;

    logic             op_valid;
    logic             op_bypass;
    ecc_pkg::data_t   op_data;
    ecc_pkg::parity_t op_parity;

    logic [31:0]      prdata;
    logic             pslverr;

    logic [31:0]      rd_data;
    logic             rd_ok;
    logic             wr_ok;
    logic             addr_err;
    logic             setup;
    logic             wr_en;
    logic             start;

    assign setup = apb_req.psel & ~apb_req.penable;
    assign wr_en = apb_req.psel & apb_req.penable & apb_req.pwrite & wr_ok;
    assign start = wr_en && (apb_req.paddr == ecc_pkg::ADDR_CTRL) && apb_req.pwdata[1];

    // Address decode and read mux.
    always_comb begin
        rd_data = '0;
        rd_ok   = 1'b1;
        wr_ok   = 1'b0;
        case (apb_req.paddr)
            ecc_pkg::ADDR_DATA_IN0: begin
                rd_data = data_in[31:0];
                wr_ok   = 1'b1;
            end
            ecc_pkg::ADDR_DATA_IN1: begin
                rd_data = data_in[63:32];
                wr_ok   = 1'b1;
            end
            ecc_pkg::ADDR_DATA_IN2: begin
                rd_data = data_in[95:64];
                wr_ok   = 1'b1;
            end
            ecc_pkg::ADDR_DATA_IN3: begin
                rd_data = {8'h00, data_in[119:96]};
                wr_ok   = 1'b1;
            end
            ecc_pkg::ADDR_PARITY_IN: begin
                rd_data = {24'h0, parity_in};
                wr_ok   = 1'b1;
            end
            ecc_pkg::ADDR_CTRL: begin
                rd_data = {31'h0, bypass}; // Start reads back as zero.
                wr_ok   = 1'b1;
            end
            ecc_pkg::ADDR_STATUS:     rd_data = {29'h0, dbit, sbit, done};
            ecc_pkg::ADDR_PARITY_OUT: rd_data = {24'h0, parity_out};
            ecc_pkg::ADDR_DATA_OUT0:  rd_data = data_out[31:0];
            ecc_pkg::ADDR_DATA_OUT1:  rd_data = data_out[63:32];
            ecc_pkg::ADDR_DATA_OUT2:  rd_data = data_out[95:64];
            ecc_pkg::ADDR_DATA_OUT3:  rd_data = {8'h00, data_out[119:96]};
            default:                  rd_ok   = 1'b0;
        endcase
        addr_err = apb_req.pwrite ? ~wr_ok : ~rd_ok;
    end

    // Response is set up in the setup phase and holds through the access phase.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prdata  <= '0;
            pslverr <= 1'b0;
        end else if (setup) begin
            prdata  <= (apb_req.pwrite || addr_err) ? '0 : rd_data;
            pslverr <= addr_err;
        end else begin
            prdata  <= '0;
            pslverr <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data_in   <= '0;
            parity_in <= '0;
            bypass    <= 1'b0;
        end else if (wr_en) begin
            case (apb_req.paddr)
                ecc_pkg::ADDR_DATA_IN0:  data_in[31:0]   <= apb_req.pwdata;
                ecc_pkg::ADDR_DATA_IN1:  data_in[63:32]  <= apb_req.pwdata;
                ecc_pkg::ADDR_DATA_IN2:  data_in[95:64]  <= apb_req.pwdata;
                ecc_pkg::ADDR_DATA_IN3:  data_in[119:96] <= apb_req.pwdata[23:0];
                ecc_pkg::ADDR_PARITY_IN: parity_in <= apb_req.pwdata[ecc_pkg::PARITY_WIDTH-1:0];
                ecc_pkg::ADDR_CTRL:      bypass    <= apb_req.pwdata[0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            op_valid <= 1'b0;
        else
            op_valid <= start; // One-cycle launch pulse.
    end

    // Bypass comes from the start write itself.
    always_ff @(posedge clk) begin
        if (start) begin
            op_bypass <= apb_req.pwdata[0];
            op_data   <= data_in;
            op_parity <= parity_in;
        end
    end

    assign op = '{valid: op_valid, bypass: op_bypass, data: op_data, parity: op_parity};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done       <= 1'b0;
            sbit       <= 1'b0;
            dbit       <= 1'b0;
            data_out   <= '0;
            parity_out <= '0;
        end else begin
            if (start)
                done <= 1'b0; // A new start outranks an older landing result.
            else if (result.valid)
                done <= 1'b1;
            if (result.valid) begin
                data_out   <= result.data;
                parity_out <= result.parity;
                sbit       <= result.sbit;
                dbit       <= result.dbit;
            end
        end
    end

    assign apb_rsp = '{prdata: prdata, pready: 1'b1, pslverr: pslverr};

endmodule

// ==== hw/ecc_correct_stage.sv ====
`timescale 1ns/1ps

module ecc_correct_stage (
    input  logic                 clk,
    input  logic                 arst_n,
    input  ecc_pkg::ecc_syn_t    syn,
    output ecc_pkg::ecc_result_t result
);

    ecc_pkg::data_t   mask;
    ecc_pkg::data_t   fixed;

    logic             valid;
    ecc_pkg::data_t   data;
    ecc_pkg::parity_t parity;
    logic             sbit;
    logic             dbit;

    assign mask  = syn.data_hit ? (ecc_pkg::data_t'(1) << syn.idx) : '0;
    assign fixed = syn.data ^ mask;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            valid <= 1'b0;
        else
            valid <= syn.valid;
    end

    always_ff @(posedge clk) begin
        if (syn.valid) begin
            parity <= syn.parity_calc;
            // Bypass returns the raw word with no error report.
            data   <= syn.bypass ? syn.data : fixed;
            sbit   <= syn.sbit & ~syn.bypass;
            dbit   <= syn.dbit & ~syn.bypass;
        end
    end

    assign result = '{valid: valid, data: data, parity: parity, sbit: sbit, dbit: dbit};

endmodule

// ==== hw/ecc_encode_stage.sv ====
`timescale 1ns/1ps

module ecc_encode_stage (
    input  logic              clk,
    input  logic              arst_n,
    input  ecc_pkg::ecc_op_t  op,
    output ecc_pkg::ecc_enc_t enc
);

    logic             valid;
    logic             bypass;
    ecc_pkg::data_t   data;
    ecc_pkg::parity_t parity;
    ecc_pkg::parity_t parity_calc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            valid <= 1'b0;
        else
            valid <= op.valid;
    end

    always_ff @(posedge clk) begin
        if (op.valid) begin
            bypass      <= op.bypass;
            data        <= op.data;
            parity      <= op.parity;
            parity_calc <= ecc_pkg::ecc_encode(op.data); // Check byte of the data as received.
        end
    end

    assign enc.op          = '{valid: valid, bypass: bypass, data: data, parity: parity};
    assign enc.parity_calc = parity_calc;

endmodule

// ==== hw/ecc_pkg.sv ====
package ecc_pkg;

    localparam int DATA_WIDTH   = 120;
    localparam int PARITY_WIDTH = 8;
    localparam int IDX_WIDTH    = 7;

    typedef logic [DATA_WIDTH-1:0]   data_t;
    typedef logic [PARITY_WIDTH-1:0] parity_t;

    // APB register byte offsets.
    localparam logic [7:0] ADDR_DATA_IN0   = 8'h00;
    localparam logic [7:0] ADDR_DATA_IN1   = 8'h04;
    localparam logic [7:0] ADDR_DATA_IN2   = 8'h08;
    localparam logic [7:0] ADDR_DATA_IN3   = 8'h0C; // Bits 119..96 in the low 24 bits.
    localparam logic [7:0] ADDR_PARITY_IN  = 8'h10;
    localparam logic [7:0] ADDR_CTRL       = 8'h14; // Bit 0 bypass, bit 1 start.
    localparam logic [7:0] ADDR_STATUS     = 8'h18; // Bit 0 done, bit 1 sbit, bit 2 dbit.
    localparam logic [7:0] ADDR_PARITY_OUT = 8'h1C;
    localparam logic [7:0] ADDR_DATA_OUT0  = 8'h20;
    localparam logic [7:0] ADDR_DATA_OUT1  = 8'h24;
    localparam logic [7:0] ADDR_DATA_OUT2  = 8'h28;
    localparam logic [7:0] ADDR_DATA_OUT3  = 8'h2C;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic    valid;
        logic    bypass;
        data_t   data;
        parity_t parity; // Received check byte.
    } ecc_op_t;

    typedef struct packed {
        ecc_op_t op;
        parity_t parity_calc;
    } ecc_enc_t;

    typedef struct packed {
        logic                 valid;
        logic                 bypass;
        data_t                data;
        parity_t              parity_calc;
        logic                 data_hit;
        logic [IDX_WIDTH-1:0] idx;
        logic                 sbit;
        logic                 dbit;
    } ecc_syn_t;

    typedef struct packed {
        logic    valid;
        data_t   data;
        parity_t parity;
        logic    sbit;
        logic    dbit;
    } ecc_result_t;

    // Data bit idx takes the idx-th position from 3 up that is not a power of two,
    // topped with an eighth bit that makes the column weight odd.
    function automatic parity_t ecc_column(input int unsigned idx);
        logic [IDX_WIDTH-1:0] pos;
        pos = IDX_WIDTH'(idx + 32'd3);
        for (int k = 2; k < IDX_WIDTH; k++) begin
            if (pos >= IDX_WIDTH'(1 << k))
                pos = pos + 1'b1; // Skip 4, 8, 16, 32 and 64.
        end
        return {~^pos, pos};
    endfunction

    function automatic parity_t ecc_encode(input data_t d);
        parity_t p;
        p = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            if (d[i])
                p = p ^ ecc_column(i);
        end
        return p;
    endfunction

endpackage

// ==== hw/ecc_syndrome_stage.sv ====
`timescale 1ns/1ps

module ecc_syndrome_stage (
    input  logic              clk,
    input  logic              arst_n,
    input  ecc_pkg::ecc_enc_t enc,
    output ecc_pkg::ecc_syn_t syn
);

    ecc_pkg::parity_t              syndrome;
    logic                          hit;
    logic [ecc_pkg::IDX_WIDTH-1:0] hit_idx;
    logic                          is_sbit;
    logic                          is_dbit;

    logic                          valid;
    logic                          bypass;
    ecc_pkg::data_t                data;
    ecc_pkg::parity_t              parity_calc;
    logic                          data_hit;
    logic [ecc_pkg::IDX_WIDTH-1:0] idx;
    logic                          sbit;
    logic                          dbit;

    assign syndrome = enc.op.parity ^ enc.parity_calc;

    // Columns are unique and have odd weight of three or more.
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < ecc_pkg::DATA_WIDTH; i++) begin
            if (syndrome == ecc_pkg::ecc_column(i)) begin
                hit     = 1'b1;
                hit_idx = ecc_pkg::IDX_WIDTH'(i);
            end
        end
    end

    assign is_sbit = hit | $onehot(syndrome); // One-hot is a flipped check bit.
    assign is_dbit = (syndrome != '0) & ~is_sbit;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            valid <= 1'b0;
        else
            valid <= enc.op.valid;
    end

    always_ff @(posedge clk) begin
        if (enc.op.valid) begin
            bypass      <= enc.op.bypass;
            data        <= enc.op.data;
            parity_calc <= enc.parity_calc;
            data_hit    <= hit;
            idx         <= hit_idx;
            sbit        <= is_sbit;
            dbit        <= is_dbit;
        end
    end

    assign syn = '{valid: valid, bypass: bypass, data: data, parity_calc: parity_calc,
                   data_hit: data_hit, idx: idx, sbit: sbit, dbit: dbit};

endmodule

// ==== hw/ecc_top.sv ====
`timescale 1ns/1ps

module ecc_top (
    input  logic              clk,
    input  logic              arst_n,
    input  ecc_pkg::apb_req_t apb_req,
    output ecc_pkg::apb_rsp_t apb_rsp
);

    ecc_pkg::ecc_op_t     op;
    ecc_pkg::ecc_enc_t    enc;
    ecc_pkg::ecc_syn_t    syn;
    ecc_pkg::ecc_result_t result;

    ecc_apb_regs u_regs (
        .clk     (clk),
        .arst_n  (arst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .op      (op),
        .result  (result)
    );

    // Three registered stages, one cycle each.
    ecc_encode_stage u_enc (
        .clk    (clk),
        .arst_n (arst_n),
        .op     (op),
        .enc    (enc)
    );

    ecc_syndrome_stage u_syn (
        .clk    (clk),
        .arst_n (arst_n),
        .enc    (enc),
        .syn    (syn)
    );

    ecc_correct_stage u_cor (
        .clk    (clk),
        .arst_n (arst_n),
        .syn    (syn),
        .result (result)
    );

endmodule

// ==== sim/ecc_chk.sv ====
`timescale 1ns/1ps

module ecc_chk (
    input logic                 clk,
    input logic                 arst_n,
    input ecc_pkg::apb_rsp_t    apb_rsp,
    input ecc_pkg::ecc_syn_t    syn,
    input ecc_pkg::ecc_result_t result
);

    int unsigned fails = 0;

    flags_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        result.valid |-> !(result.sbit && result.dbit))
    else begin
        fails++;
        $error("result carries sbit and dbit together");
    end

    no_wait_states: assert property (@(posedge clk) disable iff (!arst_n) apb_rsp.pready)
    else begin
        fails++;
        $error("pready dropped low");
    end

    // Stage 3 only forwards what stage 2 held one cycle earlier.
    result_follows_syn: assert property (@(posedge clk) disable iff (!arst_n)
        result.valid |-> $past(syn.valid))
    else begin
        fails++;
        $error("valid result without a valid syndrome item before it");
    end

endmodule

// ==== sim/ecc_monitor.sv ====
`timescale 1ns/1ps

module ecc_monitor (
    input  logic              clk,
    input  logic              arst_n,
    input  ecc_pkg::apb_req_t apb_req,
    input  ecc_pkg::apb_rsp_t apb_rsp,
    input  int unsigned       test_num,
    input  ecc_pkg::data_t    exp_data,
    input  ecc_pkg::parity_t  exp_parity,
    input  logic              exp_sbit,
    input  logic              exp_dbit,
    input  logic              test_end,
    output int unsigned       errors,
    output int unsigned       tests_failed
);

    int unsigned test_errs;

    // Writable registers take writes, read-only ones only reads, the rest nothing.
    function automatic logic access_error(input logic write, input logic [7:0] addr);
        case (addr)
            ecc_pkg::ADDR_DATA_IN0, ecc_pkg::ADDR_DATA_IN1, ecc_pkg::ADDR_DATA_IN2,
            ecc_pkg::ADDR_DATA_IN3, ecc_pkg::ADDR_PARITY_IN, ecc_pkg::ADDR_CTRL:
                return 1'b0;
            ecc_pkg::ADDR_STATUS, ecc_pkg::ADDR_PARITY_OUT, ecc_pkg::ADDR_DATA_OUT0,
            ecc_pkg::ADDR_DATA_OUT1, ecc_pkg::ADDR_DATA_OUT2, ecc_pkg::ADDR_DATA_OUT3:
                return write;
            default:
                return 1'b1;
        endcase
    endfunction

    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
        if (got !== expected) begin
            $display("[FAIL] test %0d %s: got 0x%08h, expected 0x%08h",
                     test_num, name, got, expected);
            errors++;
            test_errs++;
        end
    endtask

    task automatic check_transfer();
        logic exp_err;
        exp_err = access_error(apb_req.pwrite, apb_req.paddr);
        if (apb_rsp.pslverr !== exp_err) begin
            $display("[FAIL] test %0d pslverr at 0x%02h: got 0x%0h, expected 0x%0h",
                     test_num, apb_req.paddr, apb_rsp.pslverr, exp_err);
            errors++;
            test_errs++;
        end
        if (!apb_req.pwrite && !exp_err) begin
            case (apb_req.paddr)
                ecc_pkg::ADDR_DATA_OUT0:  compare("DATA_OUT0", apb_rsp.prdata, exp_data[31:0]);
                ecc_pkg::ADDR_DATA_OUT1:  compare("DATA_OUT1", apb_rsp.prdata, exp_data[63:32]);
                ecc_pkg::ADDR_DATA_OUT2:  compare("DATA_OUT2", apb_rsp.prdata, exp_data[95:64]);
                ecc_pkg::ADDR_DATA_OUT3:
                    compare("DATA_OUT3", apb_rsp.prdata, {8'h00, exp_data[119:96]});
                ecc_pkg::ADDR_PARITY_OUT: compare("PARITY_OUT", apb_rsp.prdata, {24'h0, exp_parity});
                ecc_pkg::ADDR_STATUS: begin
                    if (apb_rsp.prdata[0]) // Flags only mean something once done is set.
                        compare("STATUS", apb_rsp.prdata, {29'h0, exp_dbit, exp_sbit, 1'b1});
                end
                default: ;
            endcase
        end
    endtask

    always @(posedge clk) begin
        if (!arst_n) begin
            errors       = 0;
            tests_failed = 0;
            test_errs    = 0;
        end else begin
            if (apb_req.psel && apb_req.penable && apb_rsp.pready)
                check_transfer();
            if (test_end) begin
                if (test_errs == 0) begin
                    $display("test %0d: ok", test_num);
                end else begin
                    $display("test %0d: %0d mismatches", test_num, test_errs);
                    tests_failed++;
                end
                test_errs = 0;
            end
        end
    end

endmodule

// ==== sim/ecc_tests.txt ====
// First value: number of tests. Then one test per line: data, check_in, bypass,
// exp_data, exp_check, exp_sbit, exp_dbit, all in hex.
9
// Clean words: zero, bits 3..0, bit 119.
000000000000000000000000000000 00 0 000000000000000000000000000000 00 0 0
00000000000000000000000000000F 87 0 00000000000000000000000000000F 87 0 0
800000000000000000000000000000 7F 0 800000000000000000000000000000 7F 0 0
// Single data-bit flips at index 0, 119 and 60.
00000000000000000000000000000E 87 0 00000000000000000000000000000F 04 1 0
80000000000000000000000000000F 87 0 00000000000000000000000000000F F8 1 0
00000000000000100000000000000F 87 0 00000000000000000000000000000F 43 1 0
// Check bit 4 flipped.
00000000000000000000000000000F 97 0 00000000000000000000000000000F 87 1 0
// Data bits 0 and 1 flipped.
00000000000000000000000000000C 87 0 00000000000000000000000000000C 81 0 1
// Bypass with bit 0 flipped.
00000000000000000000000000000E 87 1 00000000000000000000000000000E 04 0 0

// ==== sim/tb_ecc.sv ====
`timescale 1ns/1ps

module tb_ecc;

    localparam int MAX_TESTS       = 64;
    localparam int FIELDS          = 7; // Values per test in the vector file.
    localparam int CYCLES_PER_TEST = 200;

    logic              clk;
    logic              arst_n;
    ecc_pkg::apb_req_t apb_req;
    ecc_pkg::apb_rsp_t apb_rsp;

    ecc_pkg::data_t    vectors [0:MAX_TESTS*FIELDS];
    int unsigned       n_tests;
    int unsigned       limit_cycles = 0;

    int unsigned       test_num;
    ecc_pkg::data_t    exp_data;
    ecc_pkg::parity_t  exp_parity;
    logic              exp_sbit;
    logic              exp_dbit;
    logic              test_end;
    int unsigned       errors;
    int unsigned       tests_failed;
    logic [31:0]       rdata;

    ecc_top u_ecc_top (
        .clk     (clk),
        .arst_n  (arst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    ecc_monitor u_mon (
        .clk          (clk),
        .arst_n       (arst_n),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .test_num     (test_num),
        .exp_data     (exp_data),
        .exp_parity   (exp_parity),
        .exp_sbit     (exp_sbit),
        .exp_dbit     (exp_dbit),
        .test_end     (test_end),
        .errors       (errors),
        .tests_failed (tests_failed)
    );

    bind ecc_top ecc_chk u_chk (
        .clk     (clk),
        .arst_n  (arst_n),
        .apb_rsp (apb_rsp),
        .syn     (syn),
        .result  (result)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Setup phase, then access phase until pready.
    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [31:0] wdata, output logic [31:0] data);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b1, pwrite: write, paddr: addr, pwdata: wdata};
        @(posedge clk);
        while (!apb_rsp.pready)
            @(posedge clk);
        data = apb_rsp.prdata;
        apb_req <= '0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata);
        logic [31:0] ignored;
        apb_transfer(1'b1, addr, wdata, ignored);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        apb_transfer(1'b0, addr, 32'h0, data);
    endtask

    task automatic wait_done();
        logic [31:0] status;
        status = '0;
        while (!status[0])
            apb_read(ecc_pkg::ADDR_STATUS, status);
    endtask

    task automatic read_results();
        apb_read(ecc_pkg::ADDR_DATA_OUT0, rdata);
        apb_read(ecc_pkg::ADDR_DATA_OUT1, rdata);
        apb_read(ecc_pkg::ADDR_DATA_OUT2, rdata);
        apb_read(ecc_pkg::ADDR_DATA_OUT3, rdata);
        apb_read(ecc_pkg::ADDR_PARITY_OUT, rdata);
    endtask

    task automatic close_test();
        @(posedge clk);
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
        @(posedge clk); // Monitor has logged the test by now.
    endtask

    task automatic run_vector(input int unsigned k);
        int unsigned    base;
        ecc_pkg::data_t data;
        base = 1 + k * FIELDS;
        data = vectors[base];
        test_num   <= k + 1;
        exp_data   <= vectors[base+3];
        exp_parity <= vectors[base+4][7:0];
        exp_sbit   <= vectors[base+5][0];
        exp_dbit   <= vectors[base+6][0];
        apb_write(ecc_pkg::ADDR_DATA_IN0, data[31:0]);
        apb_write(ecc_pkg::ADDR_DATA_IN1, data[63:32]);
        apb_write(ecc_pkg::ADDR_DATA_IN2, data[95:64]);
        apb_write(ecc_pkg::ADDR_DATA_IN3, {8'h00, data[119:96]});
        apb_write(ecc_pkg::ADDR_PARITY_IN, {24'h0, vectors[base+1][7:0]});
        apb_write(ecc_pkg::ADDR_CTRL, {30'h0, 1'b1, vectors[base+2][0]}); // Start, bypass.
        wait_done();
        read_results();
        close_test();
    endtask

    initial begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk);
        $display("ERROR: timeout, the tests did not finish within %0d cycles", limit_cycles);
        $display("sim failed");
        $finish;
    end

    initial begin
        apb_req    <= '0;
        arst_n     <= 1'b0;
        test_num   <= 0;
        exp_data   <= '0;
        exp_parity <= '0;
        exp_sbit   <= 1'b0;
        exp_dbit   <= 1'b0;
        test_end   <= 1'b0;
        $readmemh("sim/ecc_tests.txt", vectors);
        n_tests = vectors[0][31:0];
        if (n_tests == 0 || n_tests > MAX_TESTS) begin
            $display("ERROR: the vector file gives no usable test count");
            $display("sim failed");
            $finish;
        end else begin
            limit_cycles = (n_tests + 1) * CYCLES_PER_TEST;
            repeat (10) @(posedge clk);
            arst_n <= 1'b1;
            for (int k = 0; k < n_tests; k++)
                run_vector(k);
            // Bad accesses must leave the last result in place.
            test_num <= n_tests + 1;
            apb_write(ecc_pkg::ADDR_STATUS, 32'h0000_0006);
            apb_read(8'h40, rdata);
            wait_done();
            read_results();
            close_test();
            $display("tests run %0d, tests failed %0d, mismatches %0d, assertion failures %0d",
                     n_tests + 1, tests_failed, errors, u_ecc_top.u_chk.fails);
            if (errors == 0 && tests_failed == 0 && u_ecc_top.u_chk.fails == 0) begin
                $display("sim passed");
            end else begin
                $display("sim failed");
            end
            $finish;
        end
    end

endmodule
